// File: common/controlPkg.sv
package controlPkg;

    localparam int instructionWidth = 16;
    localparam int opcodeWidth = 4;
    localparam int extensionWidth = 4;
    localparam int registerIndexWidth = 4;
    localparam int conditionWidth = 4;
    localparam int flagCount = 5;

    // Bit positions inside the processor status register
    localparam int carryFlag = 0;
    localparam int lowFlag = 1;
    localparam int userFlag = 2;
    localparam int zeroFlag = 3;
    localparam int negativeFlag = 4;

    localparam int opcodeField = 12;
    localparam int extensionField = 4;
    localparam int targetField = 8; // Rdest, also the condition code

    typedef logic [instructionWidth-1:0] instructionT;
    typedef logic [registerIndexWidth-1:0] registerIndexT;
    typedef logic [flagCount-1:0] statusFlagsT;
    typedef logic [conditionWidth-1:0] conditionT;

    typedef enum logic [1:0] {
        fetchPhase,
        decodePhase,
        executePhase,
        writeBackPhase
    } phaseT;

    typedef enum logic [1:0] {
        upperImmediate = 2'd0,
        signedImmediate = 2'd1,
        unsignedImmediate = 2'd2,
        zeroImmediate = 2'd3 // Hard zero for jumps
    } immediateKindT;

    typedef enum logic [1:0] {
        noBranch,
        conditionalBranch,
        alwaysBranch
    } branchKindT;

    localparam logic [opcodeWidth-1:0] rTypeOp = 4'b0000;
    localparam logic [opcodeWidth-1:0] andiOp = 4'b0001;
    localparam logic [opcodeWidth-1:0] oriOp = 4'b0010;
    localparam logic [opcodeWidth-1:0] xoriOp = 4'b0011;
    localparam logic [opcodeWidth-1:0] memoryOp = 4'b0100; // Loads, stores, jumps
    localparam logic [opcodeWidth-1:0] addiOp = 4'b0101;
    localparam logic [opcodeWidth-1:0] adduiOp = 4'b0110;
    localparam logic [opcodeWidth-1:0] addciOp = 4'b0111;
    localparam logic [opcodeWidth-1:0] shiftOp = 4'b1000;
    localparam logic [opcodeWidth-1:0] subiOp = 4'b1001;
    localparam logic [opcodeWidth-1:0] subciOp = 4'b1010;
    localparam logic [opcodeWidth-1:0] cmpiOp = 4'b1011;
    localparam logic [opcodeWidth-1:0] bcondOp = 4'b1100;
    localparam logic [opcodeWidth-1:0] moviOp = 4'b1101;
    localparam logic [opcodeWidth-1:0] muliOp = 4'b1110;
    localparam logic [opcodeWidth-1:0] luiOp = 4'b1111;

    localparam logic [extensionWidth-1:0] compareExt = 4'b1011;
    localparam logic [extensionWidth-1:0] loadExt = 4'b0000;
    localparam logic [extensionWidth-1:0] storeExt = 4'b0100;
    localparam logic [extensionWidth-1:0] jcondExt = 4'b1100;
    localparam logic [extensionWidth-1:0] jalExt = 4'b1000;
    localparam logic [extensionWidth-1:0] lshExt = 4'b0100;
    localparam logic [extensionWidth-1:0] ashExt = 4'b0110;

    localparam conditionT EQ = 4'b0000;
    localparam conditionT NE = 4'b0001;
    localparam conditionT CS = 4'b0010;
    localparam conditionT CC = 4'b0011;
    localparam conditionT HI = 4'b0100;
    localparam conditionT LS = 4'b0101;
    localparam conditionT GT = 4'b0110;
    localparam conditionT LE = 4'b0111;
    localparam conditionT FS = 4'b1000;
    localparam conditionT FC = 4'b1001;
    localparam conditionT LO = 4'b1010;
    localparam conditionT HS = 4'b1011;
    localparam conditionT LT = 4'b1100;
    localparam conditionT GE = 4'b1101;
    localparam conditionT UC = 4'b1110;
    localparam conditionT NJ = 4'b1111;

endpackage

// File: source/conditionEvaluator.sv
`timescale 1ns/1ps

module conditionEvaluator import controlPkg::*; (
    input  conditionT   condition,
    input  statusFlagsT statusFlags,
    output logic        conditionMet
);

    logic carry;
    logic low;
    logic user;
    logic zero;
    logic negative;

    assign carry = statusFlags[carryFlag];
    assign low = statusFlags[lowFlag];
    assign user = statusFlags[userFlag];
    assign zero = statusFlags[zeroFlag];
    assign negative = statusFlags[negativeFlag];

    always_comb begin
        case (condition)
            EQ: conditionMet = zero;
            NE: conditionMet = !zero;
            CS: conditionMet = carry;
            CC: conditionMet = !carry;
            HI: conditionMet = low;
            LS: conditionMet = !low;
            GT: conditionMet = negative;
            LE: conditionMet = !negative;
            FS: conditionMet = user;
            FC: conditionMet = !user;
            LO: conditionMet = !low && !zero;
            HS: conditionMet = low || zero;
            LT: conditionMet = !negative && !zero;
            GE: conditionMet = zero || negative;
            UC: conditionMet = 1'b1; // Unconditional
            NJ: conditionMet = 1'b0; // Never jump
            default: conditionMet = 1'b0;
        endcase
    end

endmodule

// File: source/instructionDecoder.sv
`timescale 1ns/1ps

module instructionDecoder import controlPkg::*; (
    input  logic [opcodeWidth-1:0]    opcode,
    input  logic [extensionWidth-1:0] extension,
    output logic                      useImmediate,
    output logic                      sourceIsPc,
    output logic                      writesRegister,
    output logic                      writesMemory,
    output logic                      readsMemory,
    output logic                      skipsWriteBack,
    output immediateKindT             immediateKind,
    output branchKindT                branchKind
);

    always_comb begin
        useImmediate = 1'b0;
        sourceIsPc = 1'b0;
        writesRegister = 1'b0;
        writesMemory = 1'b0;
        readsMemory = 1'b0;
        skipsWriteBack = 1'b0;
        immediateKind = upperImmediate;
        branchKind = noBranch;
        case (opcode)
            rTypeOp: begin
                if (extension == compareExt) begin
                    skipsWriteBack = 1'b1; // CMP only sets flags
                end else begin
                    writesRegister = 1'b1;
                end
            end
            andiOp, oriOp, xoriOp, moviOp: begin
                useImmediate = 1'b1;
                immediateKind = unsignedImmediate;
                writesRegister = 1'b1;
            end
            addiOp, subiOp: begin
                useImmediate = 1'b1;
                immediateKind = signedImmediate;
                writesRegister = 1'b1;
            end
            cmpiOp: begin
                useImmediate = 1'b1;
                immediateKind = signedImmediate;
                skipsWriteBack = 1'b1;
            end
            luiOp: begin
                useImmediate = 1'b1;
                immediateKind = upperImmediate;
                writesRegister = 1'b1;
            end
            shiftOp: begin
                writesRegister = 1'b1;
                if ((extension != lshExt) && (extension != ashExt)) begin
                    useImmediate = 1'b1; // LSHI, ASHUI
                    immediateKind = upperImmediate;
                end
            end
            memoryOp: begin
                case (extension)
                    loadExt: begin
                        readsMemory = 1'b1;
                        writesRegister = 1'b1;
                    end
                    storeExt: begin
                        writesMemory = 1'b1;
                    end
                    jcondExt: begin
                        useImmediate = 1'b1;
                        immediateKind = zeroImmediate;
                        branchKind = conditionalBranch;
                    end
                    jalExt: begin
                        useImmediate = 1'b1;
                        immediateKind = zeroImmediate;
                        branchKind = alwaysBranch; // No link register write
                    end
                    default: begin
                        // Unused extension, no-op
                    end
                endcase
            end
            bcondOp: begin
                sourceIsPc = 1'b1; // PC plus displacement
                useImmediate = 1'b1;
                immediateKind = upperImmediate;
                branchKind = conditionalBranch;
            end
            adduiOp, addciOp, subciOp, muliOp: begin
                // Not implemented, runs as a no-op
            end
            default: begin
                // All opcodes are listed above
            end
        endcase
    end

endmodule

// File: source/phaseSequencer.sv
`timescale 1ns/1ps

module phaseSequencer import controlPkg::*; (
    input  logic          clock,
    input  logic          reset,
    input  logic          decodedImmediate,
    input  immediateKindT decodedKind,
    input  logic          sourceIsPc,
    input  logic          writesRegister,
    input  logic          writesMemory,
    input  logic          readsMemory,
    input  logic          skipsWriteBack,
    input  branchKindT    branchKind,
    input  logic          conditionMet,
    input  registerIndexT destination,
    output logic          instructionLoad,
    output logic          memoryRead,
    output logic          aluEnable,
    output logic          useImmediate,
    output immediateKindT immediateKind,
    output logic          aluSourceIsPc,
    output logic          pcEnable,
    output logic          pcWrite,
    output logic          registerWriteEnable,
    output registerIndexT registerWriteAddress,
    output logic          memoryWrite,
    output logic          memoryAddressFromAlu,
    output logic          writeBackFromMemory
);

    phaseT phase;
    phaseT nextPhase;
    logic takeBranch;

    always_ff @(posedge clock) begin
        if (!reset) begin
            phase <= fetchPhase;
        end else begin
            phase <= nextPhase;
        end
    end

    // Compares have nothing to write, so they finish after execute
    always_comb begin
        case (phase)
            fetchPhase: nextPhase = decodePhase;
            decodePhase: nextPhase = executePhase;
            executePhase: nextPhase = skipsWriteBack ? fetchPhase : writeBackPhase;
            default: nextPhase = fetchPhase;
        endcase
    end

    assign takeBranch = (branchKind == alwaysBranch)
                        || ((branchKind == conditionalBranch) && conditionMet);

    always_comb begin
        instructionLoad = 1'b0;
        memoryRead = 1'b0;
        aluEnable = 1'b0;
        useImmediate = 1'b0;
        immediateKind = upperImmediate;
        aluSourceIsPc = 1'b0;
        pcEnable = 1'b0;
        pcWrite = 1'b0;
        registerWriteEnable = 1'b0;
        registerWriteAddress = '0;
        memoryWrite = 1'b0;
        memoryAddressFromAlu = 1'b0;
        writeBackFromMemory = 1'b0;
        case (phase)
            fetchPhase: begin
                instructionLoad = 1'b1; // Latch the word into the IR
                memoryRead = 1'b1;
            end
            executePhase: begin
                aluEnable = 1'b1;
                useImmediate = decodedImmediate;
                immediateKind = decodedKind;
                aluSourceIsPc = sourceIsPc;
                pcEnable = skipsWriteBack; // Last phase of a compare
            end
            writeBackPhase: begin
                pcEnable = 1'b1;
                pcWrite = takeBranch; // Otherwise the PC increments
                registerWriteEnable = writesRegister;
                registerWriteAddress = writesRegister ? destination : '0;
                memoryWrite = writesMemory;
                memoryAddressFromAlu = readsMemory;
                writeBackFromMemory = readsMemory; // Load result into the register file
            end
            default: begin
                // Decode only waits for the operands
            end
        endcase
    end

endmodule

// File: source/controlUnit.sv
`timescale 1ns/1ps

module controlUnit import controlPkg::*; (
    input  logic          clock,
    input  logic          reset,
    input  instructionT   instruction,
    input  statusFlagsT   statusFlags,
    output logic          instructionLoad,
    output logic          memoryRead,
    output logic          aluEnable,
    output logic          useImmediate,
    output logic          aluSourceIsPc,
    output logic          pcEnable,
    output logic          pcWrite,
    output logic          registerWriteEnable,
    output logic          memoryWrite,
    output logic          memoryAddressFromAlu,
    output logic          writeBackFromMemory,
    output immediateKindT immediateKind,
    output registerIndexT registerWriteAddress
);

    logic [opcodeWidth-1:0] opcode;
    logic [extensionWidth-1:0] extension;
    conditionT condition;
    registerIndexT destination;

    logic decodedImmediate;
    immediateKindT decodedKind;
    logic sourceIsPc;
    logic writesRegister;
    logic writesMemory;
    logic readsMemory;
    logic skipsWriteBack;
    branchKindT branchKind;
    logic conditionMet;

    assign opcode = instruction[opcodeField +: opcodeWidth];
    assign extension = instruction[extensionField +: extensionWidth];
    assign condition = instruction[targetField +: conditionWidth]; // Shares bits with Rdest
    assign destination = instruction[targetField +: registerIndexWidth];

    instructionDecoder decoder (
        .opcode(opcode),
        .extension(extension),
        .useImmediate(decodedImmediate),
        .sourceIsPc(sourceIsPc),
        .writesRegister(writesRegister),
        .writesMemory(writesMemory),
        .readsMemory(readsMemory),
        .skipsWriteBack(skipsWriteBack),
        .immediateKind(decodedKind),
        .branchKind(branchKind)
    );

    conditionEvaluator evaluator (
        .condition(condition),
        .statusFlags(statusFlags),
        .conditionMet(conditionMet)
    );

    phaseSequencer sequencer (
        .clock(clock),
        .reset(reset),
        .decodedImmediate(decodedImmediate),
        .decodedKind(decodedKind),
        .sourceIsPc(sourceIsPc),
        .writesRegister(writesRegister),
        .writesMemory(writesMemory),
        .readsMemory(readsMemory),
        .skipsWriteBack(skipsWriteBack),
        .branchKind(branchKind),
        .conditionMet(conditionMet),
        .destination(destination),
        .instructionLoad(instructionLoad),
        .memoryRead(memoryRead),
        .aluEnable(aluEnable),
        .useImmediate(useImmediate),
        .immediateKind(immediateKind),
        .aluSourceIsPc(aluSourceIsPc),
        .pcEnable(pcEnable),
        .pcWrite(pcWrite),
        .registerWriteEnable(registerWriteEnable),
        .registerWriteAddress(registerWriteAddress),
        .memoryWrite(memoryWrite),
        .memoryAddressFromAlu(memoryAddressFromAlu),
        .writeBackFromMemory(writeBackFromMemory)
    );

endmodule

// File: verif/controlModel.svh
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

logic expInstructionLoad;
logic expMemoryRead;
logic expAluEnable;
logic expUseImmediate;
immediateKindT expImmediateKind;
logic expAluSourceIsPc;
logic expPcEnable;
logic expPcWrite;
logic expRegisterWriteEnable;
registerIndexT expRegisterWriteAddress;
logic expMemoryWrite;
logic expMemoryAddressFromAlu;
logic expWriteBackFromMemory;

// Codes come in set/clear pairs, the odd code is the inverse of the even one
function automatic logic conditionHolds(input conditionT code, input statusFlagsT flags);
    logic base;
    case (code)
        EQ, NE: base = flags[zeroFlag];
        CS, CC: base = flags[carryFlag];
        HI, LS: base = flags[lowFlag];
        GT, LE: base = flags[negativeFlag];
        FS, FC: base = flags[userFlag];
        LO, HS: base = flags[lowFlag] || flags[zeroFlag]; // HS form
        LT, GE: base = flags[zeroFlag] || flags[negativeFlag]; // GE form
        default: base = 1'b0; // NJ form
    endcase
    if (code < 4'd10) begin
        return base ^ code[0];
    end
    return base ^ !code[0];
endfunction

function automatic logic isCompare(input instructionT word);
    logic [opcodeWidth-1:0] op;
    logic [extensionWidth-1:0] ext;
    op = word[opcodeField +: opcodeWidth];
    ext = word[extensionField +: extensionWidth];
    return ((op == rTypeOp) && (ext == compareExt)) || (op == cmpiOp);
endfunction

function automatic phaseT followingPhase(input phaseT phase, input instructionT word);
    phaseT upcoming;
    case (phase)
        fetchPhase: upcoming = decodePhase;
        decodePhase: upcoming = executePhase;
        executePhase: upcoming = isCompare(word) ? fetchPhase : writeBackPhase;
        default: upcoming = fetchPhase;
    endcase
    return upcoming;
endfunction

task automatic predictOutputs(input phaseT phase, input instructionT word,
                              input statusFlagsT flags);
    logic [opcodeWidth-1:0] op;
    logic [extensionWidth-1:0] ext;
    logic immediate;
    immediateKindT kind;
    logic fromPc;
    logic regWrite;
    logic load;
    logic store;
    logic taken;
    op = word[opcodeField +: opcodeWidth];
    ext = word[extensionField +: extensionWidth];
    immediate = 1'b0;
    kind = upperImmediate;
    fromPc = 1'b0;
    regWrite = 1'b0;
    load = 1'b0;
    store = 1'b0;
    taken = 1'b0;
    case (op)
        rTypeOp: regWrite = !isCompare(word);
        andiOp, oriOp, xoriOp, moviOp: begin
            immediate = 1'b1;
            kind = unsignedImmediate;
            regWrite = 1'b1;
        end
        addiOp, subiOp, cmpiOp: begin
            immediate = 1'b1;
            kind = signedImmediate;
            regWrite = (op != cmpiOp);
        end
        luiOp: begin
            immediate = 1'b1;
            regWrite = 1'b1;
        end
        shiftOp: begin
            immediate = (ext != lshExt) && (ext != ashExt); // Immediate shift forms
            regWrite = 1'b1;
        end
        memoryOp: begin
            load = (ext == loadExt);
            store = (ext == storeExt);
            regWrite = load;
            if ((ext == jcondExt) || (ext == jalExt)) begin
                immediate = 1'b1;
                kind = zeroImmediate;
                taken = (ext == jalExt) || conditionHolds(word[targetField +: conditionWidth], flags);
            end
        end
        bcondOp: begin
            immediate = 1'b1;
            fromPc = 1'b1;
            taken = conditionHolds(word[targetField +: conditionWidth], flags);
        end
        default: begin
        end
    endcase
    expInstructionLoad = (phase == fetchPhase);
    expMemoryRead = (phase == fetchPhase);
    expAluEnable = (phase == executePhase);
    expUseImmediate = (phase == executePhase) && immediate;
    expImmediateKind = (phase == executePhase) ? kind : upperImmediate;
    expAluSourceIsPc = (phase == executePhase) && fromPc;
    expPcEnable = (phase == writeBackPhase) || ((phase == executePhase) && isCompare(word));
    expPcWrite = (phase == writeBackPhase) && taken;
    expRegisterWriteEnable = (phase == writeBackPhase) && regWrite;
    expRegisterWriteAddress = expRegisterWriteEnable ? word[targetField +: registerIndexWidth] : '0;
    expMemoryWrite = (phase == writeBackPhase) && store;
    expMemoryAddressFromAlu = (phase == writeBackPhase) && load;
    expWriteBackFromMemory = (phase == writeBackPhase) && load;
endtask

`endif

// File: verif/controlUnitTb.sv
`timescale 1ns/1ps

module controlUnitTb import controlPkg::*; ();

    localparam int instructionCount = 400;
    localparam int timeoutCycles = instructionCount * 4 + 50;

    logic clock = 1'b0;
    logic reset;
    instructionT instruction;
    statusFlagsT statusFlags;

    logic instructionLoad;
    logic memoryRead;
    logic aluEnable;
    logic useImmediate;
    logic aluSourceIsPc;
    logic pcEnable;
    logic pcWrite;
    logic registerWriteEnable;
    logic memoryWrite;
    logic memoryAddressFromAlu;
    logic writeBackFromMemory;
    immediateKindT immediateKind;
    registerIndexT registerWriteAddress;

    logic [31:0] lfsrState;
    int cycleCount = 0;
    int issued;
    phaseT expectedPhase;

    controlUnit uut (
        .clock(clock),
        .reset(reset),
        .instruction(instruction),
        .statusFlags(statusFlags),
        .instructionLoad(instructionLoad),
        .memoryRead(memoryRead),
        .aluEnable(aluEnable),
        .useImmediate(useImmediate),
        .aluSourceIsPc(aluSourceIsPc),
        .pcEnable(pcEnable),
        .pcWrite(pcWrite),
        .registerWriteEnable(registerWriteEnable),
        .memoryWrite(memoryWrite),
        .memoryAddressFromAlu(memoryAddressFromAlu),
        .writeBackFromMemory(writeBackFromMemory),
        .immediateKind(immediateKind),
        .registerWriteAddress(registerWriteAddress)
    );

    `include "controlModel.svh"

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > timeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
            stopWithFailure();
        end
    end

    function automatic logic [31:0] stepLfsr(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'hd0000001; // Taps 32, 31, 29, 1
        end
        return state >> 1;
    endfunction

    task automatic drawBits(input int count, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = stepLfsr(lfsrState);
            value = {value[14:0], lfsrState[0]};
        end
    endtask

    task automatic drawStimulus();
        logic [15:0] word;
        logic [15:0] steer;
        drawBits(16, word);
        drawBits(2, steer);
        if (steer[1:0] == 2'b11) begin
            word[opcodeField +: opcodeWidth] = memoryOp; // More loads, stores, jumps
        end
        drawBits(1, steer);
        if (steer[0]) begin
            drawBits(3, steer);
            case (steer[2:0])
                3'd0: word[extensionField +: extensionWidth] = loadExt;
                3'd1: word[extensionField +: extensionWidth] = storeExt;
                3'd2: word[extensionField +: extensionWidth] = jcondExt;
                3'd3: word[extensionField +: extensionWidth] = jalExt;
                3'd4: word[extensionField +: extensionWidth] = compareExt;
                3'd5: word[extensionField +: extensionWidth] = ashExt;
                default: begin
                end
            endcase
        end
        drawBits(flagCount, steer);
        instruction = word;
        statusFlags = steer[flagCount-1:0];
    endtask

    task automatic stopWithFailure();
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic compareValue(input string name, input logic [15:0] actual,
                                input logic [15:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
            stopWithFailure();
        end
    endtask

    task automatic checkOutputs();
        predictOutputs(expectedPhase, instruction, statusFlags);
        compareValue("instructionLoad", 16'(instructionLoad), 16'(expInstructionLoad));
        compareValue("memoryRead", 16'(memoryRead), 16'(expMemoryRead));
        compareValue("aluEnable", 16'(aluEnable), 16'(expAluEnable));
        compareValue("useImmediate", 16'(useImmediate), 16'(expUseImmediate));
        compareValue("immediateKind", 16'(immediateKind), 16'(expImmediateKind));
        compareValue("aluSourceIsPc", 16'(aluSourceIsPc), 16'(expAluSourceIsPc));
        compareValue("pcEnable", 16'(pcEnable), 16'(expPcEnable));
        compareValue("pcWrite", 16'(pcWrite), 16'(expPcWrite));
        compareValue("registerWriteEnable", 16'(registerWriteEnable),
                     16'(expRegisterWriteEnable));
        compareValue("registerWriteAddress", 16'(registerWriteAddress),
                     16'(expRegisterWriteAddress));
        compareValue("memoryWrite", 16'(memoryWrite), 16'(expMemoryWrite));
        compareValue("memoryAddressFromAlu", 16'(memoryAddressFromAlu),
                     16'(expMemoryAddressFromAlu));
        compareValue("writeBackFromMemory", 16'(writeBackFromMemory),
                     16'(expWriteBackFromMemory));
    endtask

    initial begin
        reset = 1'b0;
        instruction = '0;
        statusFlags = '0;
        lfsrState = 32'hf29c;
        issued = 0;
        expectedPhase = fetchPhase;
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        // Outputs are checked mid-cycle, new words go in during fetch
        while (!((expectedPhase == fetchPhase) && (issued == instructionCount))) begin
            checkOutputs();
            if (expectedPhase == fetchPhase) begin
                drawStimulus();
                issued++;
            end
            expectedPhase = followingPhase(expectedPhase, instruction);
            @(negedge clock);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+verif
common/controlPkg.sv
source/conditionEvaluator.sv
source/instructionDecoder.sv
source/phaseSequencer.sv
source/controlUnit.sv
verif/controlUnitTb.sv

// File: run.sh
#!/bin/sh
# Build and run the control unit testbench with Verilator.
# The exit status is nonzero when any check fails or the run times out.
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module controlUnitTb \
    -f verilog.f \
    -o controlUnitSim

./obj_dir/controlUnitSim
